// ==== Bender.yml ====
package:
  name: noise_channel

sources:
  - src/noise_pkg.sv
  - src/noise_reg_file.sv
  - src/noise_period_timer.sv
  - src/noise_random_lfsr.sv
  - src/noise_envelope.sv
  - src/noise_length_counter.sv
  - src/noise_channel.sv
  - target: test
    files:
      - tb/noise_channel_checker.sv
      - tb/noise_channel_tb.sv

// ==== compile.f ====
src/noise_pkg.sv
src/noise_reg_file.sv
src/noise_period_timer.sv
src/noise_random_lfsr.sv
src/noise_envelope.sv
src/noise_length_counter.sv
src/noise_channel.sv
tb/noise_channel_checker.sv
tb/noise_channel_tb.sv

// ==== src/noise_channel.sv ====
module noise_channel (
	input  logic                 ACLK,
	input  logic                 reset,
	input  noise_pkg::regWrite_t regWrite,
	input  logic                 regWriteValid,
	input  logic                 quarterFrame,
	input  logic                 halfFrame,
	input  logic                 channelEnable,
	output logic [3:0]           level,
	output logic                 lengthActive
);

	noise_pkg::noiseRegs_t regs;
	logic                  lengthLoad;
	logic [4:0]            lengthIndex;
	logic                  envelopeStart;
	logic                  step;
	logic                  randomBit;
	logic [3:0]            volumeOut;

	noise_reg_file regFile (
		.ACLK          (ACLK),
		.reset         (reset),
		.regWrite      (regWrite),
		.regWriteValid (regWriteValid),
		.regs          (regs),
		.lengthLoad    (lengthLoad),
		.lengthIndex   (lengthIndex),
		.envelopeStart (envelopeStart)
	);

	noise_period_timer periodTimer (
		.ACLK        (ACLK),
		.reset       (reset),
		.periodIndex (regs.periodIndex),
		.step        (step)
	);

	noise_random_lfsr randomLfsr (
		.ACLK      (ACLK),
		.reset     (reset),
		.step      (step),
		.shortMode (regs.shortMode),
		.randomBit (randomBit)
	);

	noise_envelope envelope (
		.ACLK          (ACLK),
		.reset         (reset),
		.quarterFrame  (quarterFrame),
		.envelopeStart (envelopeStart),
		.regs          (regs),
		.volumeOut     (volumeOut)
	);

	noise_length_counter lengthCounter (
		.ACLK          (ACLK),
		.reset         (reset),
		.halfFrame     (halfFrame),
		.channelEnable (channelEnable),
		.lengthLoad    (lengthLoad),
		.lengthIndex   (lengthIndex),
		.haltLength    (regs.haltLength),
		.lengthActive  (lengthActive)
	);

	// Silent when the random bit is set or length has run out
	assign level = (!randomBit && lengthActive) ? volumeOut : 4'd0;

endmodule

// ==== src/noise_envelope.sv ====
module noise_envelope (
	input  logic                  ACLK,
	input  logic                  reset,
	input  logic                  quarterFrame,
	input  logic                  envelopeStart,
	input  noise_pkg::noiseRegs_t regs,
	output logic [3:0]            volumeOut
);

	logic       startFlag;
	logic [3:0] divider;
	logic [3:0] decay;
	logic       dividerZero;

	assign dividerZero = (divider == 4'd0);

	always_ff @(posedge ACLK) begin
		if (reset) begin
			startFlag <= 1'b0;
			divider   <= 4'd0;
			decay     <= 4'd0;
		end else begin
			if (quarterFrame) begin
				if (startFlag) begin
					startFlag <= 1'b0;
					decay     <= 4'd15;
					divider   <= regs.volume;
				end else if (dividerZero) begin
					divider <= regs.volume; // Divider period is the volume field
					if (decay != 4'd0) begin
						decay <= decay - 1'b1;
					end else if (regs.haltLength) begin
						decay <= 4'd15; // Loop
					end
				end else begin
					divider <= divider - 1'b1;
				end
			end
			// A fresh length write wins over a clearing tick in the same cycle
			if (envelopeStart) begin
				startFlag <= 1'b1;
			end
		end
	end

	assign volumeOut = regs.constVolume ? regs.volume : decay;

endmodule

// ==== src/noise_length_counter.sv ====
module noise_length_counter (
	input  logic       ACLK,
	input  logic       reset,
	input  logic       halfFrame,
	input  logic       channelEnable,
	input  logic       lengthLoad,
	input  logic [4:0] lengthIndex,
	input  logic       haltLength,
	output logic       lengthActive
);

	logic [7:0] count;
	logic       countDown;

	assign countDown = halfFrame && !haltLength && (count != 8'd0);

	// Enable clear beats load, load beats decrement
	always_ff @(posedge ACLK) begin
		if (reset) begin
			count <= 8'd0;
		end else if (!channelEnable) begin
			count <= 8'd0;
		end else if (lengthLoad) begin
			count <= noise_pkg::lengthTable[lengthIndex];
		end else if (countDown) begin
			count <= count - 1'b1;
		end
	end

	assign lengthActive = (count != 8'd0);

endmodule

// ==== src/noise_period_timer.sv ====
module noise_period_timer (
	input  logic       ACLK,
	input  logic       reset,
	input  logic [3:0] periodIndex,
	output logic       step
);

	logic [noise_pkg::TimerWidth-1:0] count;
	logic [noise_pkg::TimerWidth-1:0] reloadValue;
	logic                             atZero;

	// New index is only seen at the next reload
	assign reloadValue = noise_pkg::periodTable[periodIndex];
	assign atZero      = (count == '0);

	always_ff @(posedge ACLK) begin
		if (reset) begin
			count <= '0;
		end else if (atZero) begin
			count <= reloadValue;
		end else begin
			count <= count - 1'b1;
		end
	end

	// Step spacing is table value plus one
	always_ff @(posedge ACLK) begin
		if (reset) begin
			step <= 1'b0;
		end else begin
			step <= atZero;
		end
	end

endmodule

// ==== src/noise_pkg.sv ====
package noise_pkg;

	// One register write from the CPU side
	typedef struct packed {
		logic [1:0] addr; // 0 control, 1 unused, 2 mode/period, 3 length
		logic [7:0] data;
	} regWrite_t;

	// Held register fields of the channel
	typedef struct packed {
		logic       haltLength;  // Also envelope loop
		logic       constVolume;
		logic [3:0] volume;      // Volume or envelope divider period
		logic       shortMode;
		logic [3:0] periodIndex;
	} noiseRegs_t;

	localparam int LfsrWidth  = 15;
	localparam int TimerWidth = 12;

	// NTSC noise periods in timer clocks
	localparam logic [TimerWidth-1:0] periodTable [16] = '{
		12'd4,    12'd8,    12'd16,   12'd32,
		12'd64,   12'd96,   12'd128,  12'd160,
		12'd202,  12'd254,  12'd380,  12'd508,
		12'd762,  12'd1016, 12'd2034, 12'd4068
	};

	// Length counter load values, indexed by data[7:3]
	localparam logic [7:0] lengthTable [32] = '{
		8'd10,  8'd254, 8'd20,  8'd2,
		8'd40,  8'd4,   8'd80,  8'd6,
		8'd160, 8'd8,   8'd60,  8'd10,
		8'd14,  8'd12,  8'd26,  8'd14,
		8'd12,  8'd16,  8'd24,  8'd18,
		8'd48,  8'd20,  8'd96,  8'd22,
		8'd192, 8'd24,  8'd72,  8'd26,
		8'd16,  8'd28,  8'd32,  8'd30
	};

endpackage

// ==== src/noise_random_lfsr.sv ====
module noise_random_lfsr (
	input  logic ACLK,
	input  logic reset,
	input  logic step,
	input  logic shortMode,
	output logic randomBit
);

	logic [noise_pkg::LfsrWidth-1:0] lfsrState;
	logic                            feedback;

	// Short mode taps bit 6 for the 93-step sequence
	assign feedback = lfsrState[0] ^ (shortMode ? lfsrState[6] : lfsrState[1]);

	always_ff @(posedge ACLK) begin
		if (reset) begin
			lfsrState <= noise_pkg::LfsrWidth'(1); // Must never be all zero
		end else if (step) begin
			lfsrState <= {feedback, lfsrState[noise_pkg::LfsrWidth-1:1]};
		end
	end

	assign randomBit = lfsrState[0]; // Set bit mutes the channel

endmodule

// ==== src/noise_reg_file.sv ====
module noise_reg_file (
	input  logic                  ACLK,
	input  logic                  reset,
	input  noise_pkg::regWrite_t  regWrite,
	input  logic                  regWriteValid,
	output noise_pkg::noiseRegs_t regs,
	output logic                  lengthLoad,
	output logic [4:0]            lengthIndex,
	output logic                  envelopeStart
);

	localparam logic [1:0] AddrControl = 2'd0;
	localparam logic [1:0] AddrPeriod  = 2'd2;
	localparam logic [1:0] AddrLength  = 2'd3;

	logic controlWrite;
	logic periodWrite;
	logic lengthWrite;

	assign controlWrite = regWriteValid && (regWrite.addr == AddrControl);
	assign periodWrite  = regWriteValid && (regWrite.addr == AddrPeriod);
	assign lengthWrite  = regWriteValid && (regWrite.addr == AddrLength); // Address 1 falls through

	always_ff @(posedge ACLK) begin
		if (reset) begin
			regs <= '0;
		end else begin
			if (controlWrite) begin
				regs.haltLength  <= regWrite.data[5];
				regs.constVolume <= regWrite.data[4];
				regs.volume      <= regWrite.data[3:0];
			end
			if (periodWrite) begin
				regs.shortMode   <= regWrite.data[7];
				regs.periodIndex <= regWrite.data[3:0];
			end
		end
	end

	// A length write also restarts the envelope
	always_ff @(posedge ACLK) begin
		if (reset) begin
			lengthLoad    <= 1'b0;
			envelopeStart <= 1'b0;
			lengthIndex   <= '0;
		end else begin
			lengthLoad    <= lengthWrite; // One cycle pulse
			envelopeStart <= lengthWrite;
			if (lengthWrite) begin
				lengthIndex <= regWrite.data[7:3];
			end
		end
	end

endmodule

// ==== tb/noise_channel_checker.sv ====
module noise_channel_checker (
	input logic                            ACLK,
	input logic                            reset,
	input logic                            step,
	input logic                            lengthLoad,
	input logic                            lengthActive,
	input logic [3:0]                      level,
	input logic [noise_pkg::LfsrWidth-1:0] lfsrState
);

	int failures = 0; // Read by the testbench at the end

	lfsrNonZero: assert property (@(posedge ACLK) disable iff (reset) lfsrState != '0)
		else begin
			$error("shift register state reached zero");
			failures++;
		end

	silentWhenInactive: assert property (@(posedge ACLK) disable iff (reset)
		!lengthActive |-> level == 4'd0)
		else begin
			$error("level nonzero while length counter is empty");
			failures++;
		end

	stepSingle: assert property (@(posedge ACLK) disable iff (reset) step |=> !step)
		else begin
			$error("step held high for two cycles");
			failures++;
		end

	loadSingle: assert property (@(posedge ACLK) disable iff (reset) lengthLoad |=> !lengthLoad)
		else begin
			$error("lengthLoad held high for two cycles");
			failures++;
		end

endmodule

// Shift register state is reached through the instance inside the DUT
bind noise_channel noise_channel_checker assertChecks (
	.ACLK         (ACLK),
	.reset        (reset),
	.step         (step),
	.lengthLoad   (lengthLoad),
	.lengthActive (lengthActive),
	.level        (level),
	.lfsrState    (randomLfsr.lfsrState)
);

// ==== tb/noise_channel_tb.sv ====
module noise_channel_tb;

	localparam logic [11:0] refPeriod [16] = '{
		12'd4, 12'd8, 12'd16, 12'd32, 12'd64, 12'd96, 12'd128, 12'd160,
		12'd202, 12'd254, 12'd380, 12'd508, 12'd762, 12'd1016, 12'd2034, 12'd4068
	};
	localparam logic [7:0] refLength [32] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	logic                 ACLK;
	logic                 reset;
	noise_pkg::regWrite_t regWrite;
	logic                 regWriteValid;
	logic                 quarterFrame;
	logic                 halfFrame;
	logic                 channelEnable;
	logic [3:0]           level;
	logic                 lengthActive;

	logic [31:0] randState = 32'd12;
	string       curTest;
	int          testErrors;
	int          passCount;
	int          failCount;
	int          checkerFails;
	int          pulses;
	logic [15:0] r;
	logic [1:0]  addr;
	logic        lastLength;
	logic [4:0]  idx;

	// Channel model state
	logic        mHalt, mConstVol, mShort, mLenLoad, mEnvStart, mStep, mStartFlag;
	logic [3:0]  mVolume, mPeriodIdx, mDivider, mDecay;
	logic [4:0]  mLenIdx;
	logic [11:0] mTimer;
	logic [14:0] mLfsr;
	logic [7:0]  mLenCount;

	noise_channel noise_channel_i (
		.ACLK          (ACLK),
		.reset         (reset),
		.regWrite      (regWrite),
		.regWriteValid (regWriteValid),
		.quarterFrame  (quarterFrame),
		.halfFrame     (halfFrame),
		.channelEnable (channelEnable),
		.level         (level),
		.lengthActive  (lengthActive)
	);

	initial ACLK = 1'b0;
	always #50 ACLK = ~ACLK;

	function automatic logic [15:0] nextRand();
		randState = randState * 32'd1103515245 + 32'd12345;
		return randState[31:16];
	endfunction

	// Consumers first so every block sees last cycle's values
	task automatic modelEdge();
		logic atZero;
		logic feedback;
		if (reset) begin
			{mHalt, mConstVol, mVolume, mShort, mPeriodIdx} = '0;
			{mLenLoad, mEnvStart, mLenIdx, mTimer, mStep} = '0;
			{mStartFlag, mDivider, mDecay, mLenCount} = '0;
			mLfsr = 15'd1;
		end else begin
			if (mStep) begin
				feedback = mLfsr[0] ^ (mShort ? mLfsr[6] : mLfsr[1]);
				mLfsr = {feedback, mLfsr[14:1]};
			end
			if (quarterFrame) begin
				if (mStartFlag) begin
					mStartFlag = 1'b0;
					mDecay = 4'd15;
					mDivider = mVolume;
				end else if (mDivider == 4'd0) begin
					mDivider = mVolume;
					if (mDecay != 4'd0) mDecay = mDecay - 1'b1;
					else if (mHalt) mDecay = 4'd15;
				end else begin
					mDivider = mDivider - 1'b1;
				end
			end
			if (mEnvStart) mStartFlag = 1'b1;
			if (!channelEnable) mLenCount = 8'd0;
			else if (mLenLoad) mLenCount = refLength[mLenIdx];
			else if (halfFrame && !mHalt && mLenCount != 8'd0) mLenCount = mLenCount - 1'b1;
			atZero = (mTimer == 12'd0);
			mTimer = atZero ? refPeriod[mPeriodIdx] : mTimer - 1'b1;
			mStep = atZero;
			mLenLoad = regWriteValid && regWrite.addr == 2'd3;
			mEnvStart = mLenLoad;
			if (mLenLoad) mLenIdx = regWrite.data[7:3];
			if (regWriteValid && regWrite.addr == 2'd0) begin
				{mHalt, mConstVol, mVolume} = regWrite.data[5:0];
			end
			if (regWriteValid && regWrite.addr == 2'd2) begin
				mShort = regWrite.data[7];
				mPeriodIdx = regWrite.data[3:0];
			end
		end
	endtask

	function automatic logic [3:0] expectedLevel();
		logic [3:0] vol;
		vol = mConstVol ? mVolume : mDecay;
		return (!mLfsr[0] && mLenCount != 8'd0) ? vol : 4'd0;
	endfunction

	task automatic checkOutputs();
		logic [3:0] expLevel;
		expLevel = expectedLevel();
		assert (level == expLevel) else begin
			$display("error %s level expected %0d actual %0d", curTest, expLevel, level);
			testErrors++;
		end
		assert (lengthActive == (mLenCount != 8'd0)) else begin
			$display("error %s lengthActive expected %0d actual %0d", curTest,
				mLenCount != 8'd0, lengthActive);
			testErrors++;
		end
	endtask

	// Model steps at the edge, outputs are compared and inputs driven 5 units later
	task automatic stepCycle();
		@(posedge ACLK);
		modelEdge();
		#5;
		checkOutputs();
		regWriteValid = 1'b0;
		quarterFrame = 1'b0;
		halfFrame = 1'b0;
	endtask

	task automatic doWrite(input logic [1:0] a, input logic [7:0] d);
		regWrite.addr = a;
		regWrite.data = d;
		regWriteValid = 1'b1;
		stepCycle();
	endtask

	task automatic finishTest();
		if (testErrors == 0) begin
			passCount++;
			$display("test %s: ok", curTest);
		end else begin
			failCount++;
			$display("test %s: %0d errors", curTest, testErrors);
		end
		testErrors = 0;
	endtask

	task automatic envelopeRun(input logic halt);
		r = nextRand();
		doWrite(2'd0, {2'b00, halt, 1'b0, 2'b00, r[1:0]}); // Small divider period
		doWrite(2'd3, {5'd1, 3'b000}); // Restart envelope
		repeat (400) begin
			r = nextRand();
			quarterFrame = (r[1:0] == 2'd0);
			stepCycle();
		end
	endtask

	initial begin
		reset = 1'b1;
		regWrite = '0;
		regWriteValid = 1'b0;
		quarterFrame = 1'b0;
		halfFrame = 1'b0;
		channelEnable = 1'b0;
		{testErrors, passCount, failCount} = '0;
		lastLength = 1'b0;

		curTest = "reset";
		repeat (10) stepCycle();
		reset = 1'b0;
		channelEnable = 1'b1;
		repeat (30) begin
			stepCycle();
			assert (level == 4'd0) else begin
				$display("error %s level expected 0 actual %0d", curTest, level);
				testErrors++;
			end
			assert (!lengthActive) else begin
				$display("error %s lengthActive expected 0 actual %0d", curTest,
					lengthActive);
				testErrors++;
			end
		end
		finishTest();

		curTest = "constant_volume";
		doWrite(2'd3, {5'd1, 3'b000});
		repeat (4) begin
			r = nextRand();
			doWrite(2'd0, {4'b0001, r[3:0] | 4'd1}); // Constant volume, nonzero
			doWrite(2'd2, {4'b0000, 2'b00, r[5:4]});
			repeat (150) stepCycle();
		end
		finishTest();

		curTest = "short_mode";
		doWrite(2'd3, {5'd1, 3'b000});
		repeat (4) begin
			r = nextRand();
			doWrite(2'd0, {4'b0001, r[3:0] | 4'd1});
			doWrite(2'd2, {4'b1000, 2'b00, r[5:4]});
			repeat (200) stepCycle();
		end
		finishTest();

		curTest = "envelope";
		doWrite(2'd2, 8'h00);
		envelopeRun(1'b0);
		envelopeRun(1'b1); // Decay loops back to 15
		finishTest();

		curTest = "length_counter";
		doWrite(2'd0, 8'h1F);
		r = nextRand();
		idx = {2'b00, r[1:0], 1'b1} + 5'd2; // Indices 3, 5, 7, 9
		doWrite(2'd3, {idx, 3'b000});
		stepCycle();
		pulses = 0;
		while (lengthActive && pulses < 300) begin
			halfFrame = 1'b1;
			stepCycle();
			pulses++;
			stepCycle();
		end
		if (lengthActive) begin
			$display("timeout in %s: lengthActive never changed as expected", curTest);
			testErrors++;
		end
		assert (pulses == refLength[idx]) else begin
			$display("error %s halfFrame count expected %0d actual %0d", curTest,
				refLength[idx], pulses);
			testErrors++;
		end
		doWrite(2'd0, 8'h3F); // Halt set
		doWrite(2'd3, {5'd3, 3'b000});
		repeat (10) begin
			halfFrame = 1'b1;
			stepCycle();
		end
		assert (lengthActive) else begin
			$display("error %s lengthActive expected 1 actual 0", curTest);
			testErrors++;
		end
		channelEnable = 1'b0;
		stepCycle();
		assert (!lengthActive) else begin
			$display("error %s lengthActive expected 0 actual 1", curTest);
			testErrors++;
		end
		channelEnable = 1'b1;
		finishTest();

		curTest = "mixed_traffic";
		repeat (3000) begin
			r = nextRand();
			addr = r[5:4];
			if (addr == 2'd3 && lastLength) addr = 2'd0; // No back-to-back length loads
			if (r[3:0] < 4'd4) begin
				regWrite.addr = addr;
				regWrite.data = r[15:8];
				regWriteValid = 1'b1;
			end
			lastLength = regWriteValid && addr == 2'd3;
			r = nextRand();
			quarterFrame = (r[2:0] == 3'd0);
			halfFrame = (r[6:3] == 4'd0);
			if (r[12:7] == 6'd0) channelEnable = ~channelEnable;
			stepCycle();
		end
		finishTest();

		checkerFails = noise_channel_i.assertChecks.failures;
		if (checkerFails != 0) begin
			$display("concurrent assertions failed %0d times", checkerFails);
		end
		$display("tests passing %0d, failing %0d", passCount, failCount);
		if (failCount == 0 && checkerFails == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
